// ==== design/cpu_isa_pkg.sv ====
`default_nettype none

package cpu_isa_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_addr_t;
   // Word address into 2048 words
   typedef logic [10:0] mem_addr_t;

   // Bits 31:27 of every instruction
   typedef enum logic [4:0] {
      NOP  = 5'd0,
      LDI  = 5'd1,
      LDM  = 5'd2,
      ST   = 5'd3,
      ALU  = 5'd4,
      JNZ  = 5'd5,
      HALT = 5'd6
   } instr_type_e;

   typedef enum logic [3:0] {
      OP_ADD = 4'd0,
      OP_SUB = 4'd1,
      OP_AND = 4'd2,
      OP_OR  = 4'd3,
      OP_XOR = 4'd4,
      OP_SHL = 4'd5,
      OP_SHR = 4'd6,
      OP_SLT = 4'd7
   } alu_op_e;

   localparam int unsigned TYPE_LSB   = 27;
   localparam int unsigned RD_LSB     = 22;
   localparam int unsigned RA_LSB     = 17;
   localparam int unsigned RB_LSB     = 12;
   localparam int unsigned ALU_OP_LSB = 0;
   localparam int unsigned IMM_W      = 16;

   localparam reg_addr_t REG_ZERO = 5'd0;

endpackage

`default_nettype wire

// ==== design/cpu_ctrl_pkg.sv ====
`default_nettype none

package cpu_ctrl_pkg;

   typedef enum logic [2:0] {
      FETCH = 3'd0,
      ISSUE = 3'd1,
      READ  = 3'd2,
      EXEC  = 3'd3,
      WB    = 3'd4
   } stage_e;

   typedef enum logic {
      IDLE = 1'b0,
      RUN  = 1'b1
   } run_state_e;

   // Write-back source select
   typedef logic [1:0] wb_sel_t;

   localparam wb_sel_t WB_IMM = 2'd0;
   localparam wb_sel_t WB_ALU = 2'd1;
   localparam wb_sel_t WB_MEM = 2'd2;

endpackage

`default_nettype wire

// ==== design/cpu_ifs.sv ====
`default_nettype none

// Main memory port; rdata follows raddr by one cycle
interface mem_if import cpu_isa_pkg::*; ();

   mem_addr_t raddr;
   word_t     rdata;
   mem_addr_t waddr;
   word_t     wdata;
   logic      wen;

   modport core (output raddr, output waddr, output wdata, output wen, input rdata);
   modport mem (input raddr, input waddr, input wdata, input wen, output rdata);

endinterface

// Register file port; read data is registered
interface rf_if import cpu_isa_pkg::*; ();

   reg_addr_t rd_addr0;
   reg_addr_t rd_addr1;
   word_t     rd_data0;
   word_t     rd_data1;
   reg_addr_t wr_addr;
   word_t     wr_data;
   logic      wr_en;

   modport ctrl (output rd_addr0, output rd_addr1, output wr_addr, output wr_en,
                 input rd_data0, input rd_data1);
   modport file (input rd_addr0, input rd_addr1, input wr_addr, input wr_en,
                 output rd_data0, output rd_data1, output wr_data);

endinterface

`default_nettype wire

// ==== design/fetch_sequencer.sv ====
`default_nettype none

module fetch_sequencer
   import cpu_isa_pkg::*, cpu_ctrl_pkg::*;
#(
   parameter int MEM_DEPTH = 2048
) (
   input  wire     clk,
   input  wire     rst,
   input  wire     start,
   output logic    halted,
   output logic    busy,
   mem_if.core     mem,
   rf_if.ctrl      rf,
   output alu_op_e alu_op,
   output word_t   imm,
   output wb_sel_t wb_sel
);

   localparam mem_addr_t ADDR_MASK = mem_addr_t'(MEM_DEPTH - 1);

   stage_e      stage;
   run_state_e  run_state;
   mem_addr_t   pc;
   word_t       ir;
   instr_type_e itype;
   logic        jump_taken;

   assign busy  = (run_state == RUN);
   assign itype = instr_type_e'(ir[TYPE_LSB +: 5]);

   // Condition in ra, target in rb
   assign jump_taken = (itype == JNZ) && (rf.rd_data0 != '0);

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         run_state <= IDLE;
         stage     <= FETCH;
         pc        <= '0;
         halted    <= 1'b0;
      end else if (run_state == IDLE) begin
         if (start) begin
            run_state <= RUN;
            pc        <= '0;
            halted    <= 1'b0;
         end
      end else begin
         case (stage)
            FETCH: stage <= ISSUE;
            ISSUE: stage <= READ;
            READ:  stage <= EXEC;
            EXEC:  stage <= WB;
            default: begin
               stage <= FETCH;
               if (itype == HALT) begin
                  run_state <= IDLE;
                  halted    <= 1'b1;
               end else if (jump_taken) begin
                  pc <= mem_addr_t'(rf.rd_data1) & ADDR_MASK;
               end else begin
                  pc <= (pc + 1'b1) & ADDR_MASK;
               end
            end
         endcase
      end
   end

   // Instruction word arrives from memory during ISSUE
   always_ff @(posedge clk) begin
      if (busy && stage == ISSUE) begin
         ir <= mem.rdata;
      end
   end

   assign rf.rd_addr0 = ir[RA_LSB +: 5];
   assign rf.rd_addr1 = ir[RB_LSB +: 5];
   assign rf.wr_addr  = ir[RD_LSB +: 5];
   assign rf.wr_en    = busy && (stage == WB) && (itype inside {LDI, LDM, ALU});

   assign wb_sel = (itype == LDI) ? WB_IMM : (itype == LDM) ? WB_MEM : WB_ALU;
   assign alu_op = alu_op_e'(ir[ALU_OP_LSB +: 4]);
   assign imm    = {{(32 - IMM_W){ir[IMM_W-1]}}, ir[IMM_W-1:0]};

   // Load address from ra in EXEC, otherwise the PC
   assign mem.raddr = (stage == EXEC && itype == LDM) ?
                      (mem_addr_t'(rf.rd_data0) & ADDR_MASK) : pc;
   assign mem.waddr = mem_addr_t'(rf.rd_data0) & ADDR_MASK;
   assign mem.wdata = rf.rd_data1;
   assign mem.wen   = busy && (stage == EXEC) && (itype == ST);

   assert property (@(posedge clk) disable iff (!rst)
      (run_state == IDLE) |-> (stage == FETCH));

   assert property (@(posedge clk) disable iff (!rst) !(halted && busy));

endmodule

`default_nettype wire

// ==== design/alu.sv ====
`default_nettype none

module alu
   import cpu_isa_pkg::*;
(
   input  wire word_t   a,
   input  wire word_t   b,
   input  wire alu_op_e op,
   output word_t        result
);

   logic [4:0] shamt;
   logic       less;

   // Only the low bits of b count for shifts
   assign shamt = b[4:0];
   assign less  = $signed(a) < $signed(b);

   always_comb begin
      case (op)
         OP_ADD:  result = a + b;
         OP_SUB:  result = a - b;
         OP_AND:  result = a & b;
         OP_OR:   result = a | b;
         OP_XOR:  result = a ^ b;
         OP_SHL:  result = a << shamt;
         OP_SHR:  result = a >> shamt;
         OP_SLT:  result = {31'd0, less};
         default: result = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== design/main_memory.sv ====
`default_nettype none

module main_memory
   import cpu_isa_pkg::*;
#(
   parameter int MEM_DEPTH = 2048
) (
   input  wire            clk,
   input  wire            rst,
   mem_if.mem             mem,
   input  wire            busy,
   input  wire            load_req,
   input  wire mem_addr_t load_addr,
   input  wire word_t     load_data,
   output logic           load_ack
);

   localparam mem_addr_t ADDR_MASK = mem_addr_t'(MEM_DEPTH - 1);

   word_t ram [MEM_DEPTH];
   logic  host_wr;

   // New load accepted only while the core is idle
   assign host_wr = load_req && !load_ack && !busy;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         load_ack <= 1'b0;
      end else if (host_wr) begin
         load_ack <= 1'b1;
      end else if (load_ack && !load_req) begin
         load_ack <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (host_wr) begin
         ram[load_addr & ADDR_MASK] <= load_data;
      end else if (mem.wen) begin
         ram[mem.waddr & ADDR_MASK] <= mem.wdata;
      end
      mem.rdata <= ram[mem.raddr & ADDR_MASK];
   end

   assert property (@(posedge clk) disable iff (!rst) $rose(load_ack) |-> !busy);

endmodule

`default_nettype wire

// ==== design/register_file.sv ====
`default_nettype none

module register_file
   import cpu_isa_pkg::*, cpu_ctrl_pkg::*;
(
   input  wire            clk,
   input  wire            rst,
   rf_if.file             rf,
   input  wire            busy,
   input  wire wb_sel_t   wb_sel,
   input  wire word_t     imm,
   input  wire word_t     alu_result,
   input  wire word_t     mem_rdata,
   input  wire            dbg_req,
   input  wire reg_addr_t dbg_reg,
   output word_t          dbg_data,
   output logic           dbg_ack
);

   word_t     regs [32];
   reg_addr_t addr0;

   // Port 0 belongs to the debug path while idle
   assign addr0 = busy ? rf.rd_addr0 : dbg_reg;

   always_comb begin
      case (wb_sel)
         WB_IMM:  rf.wr_data = imm;
         WB_MEM:  rf.wr_data = mem_rdata;
         default: rf.wr_data = alu_result;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rf.wr_en && rf.wr_addr != REG_ZERO) begin
         regs[rf.wr_addr] <= rf.wr_data;
      end
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         rf.rd_data0 <= '0;
         rf.rd_data1 <= '0;
      end else begin
         rf.rd_data0 <= (addr0 == REG_ZERO) ? '0 : regs[addr0];
         rf.rd_data1 <= (rf.rd_addr1 == REG_ZERO) ? '0 : regs[rf.rd_addr1];
      end
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         dbg_ack <= 1'b0;
      end else if (!dbg_ack && dbg_req && !busy) begin
         dbg_ack <= 1'b1;
      end else if (dbg_ack && !dbg_req) begin
         dbg_ack <= 1'b0;
      end
   end

   assign dbg_data = rf.rd_data0;

   assert property (@(posedge clk) disable iff (!rst) !(rf.wr_en && dbg_ack));

endmodule

`default_nettype wire

// ==== design/cpu_top.sv ====
`default_nettype none

module cpu_top
   import cpu_isa_pkg::*, cpu_ctrl_pkg::*;
#(
   parameter int MEM_DEPTH = 2048
) (
   input  wire            clk,
   input  wire            rst,
   input  wire            start,
   output wire            halted,
   input  wire            load_req,
   input  wire mem_addr_t load_addr,
   input  wire word_t     load_data,
   output wire            load_ack,
   input  wire            dbg_req,
   input  wire reg_addr_t dbg_reg,
   output wire word_t     dbg_data,
   output wire            dbg_ack
);

   logic    busy;
   alu_op_e alu_op;
   word_t   imm;
   word_t   alu_result;
   wb_sel_t wb_sel;

   mem_if mem_bus ();
   rf_if  rf_bus ();

   fetch_sequencer #(.MEM_DEPTH(MEM_DEPTH)) fetch_sequencer_inst (
      .clk    (clk),
      .rst    (rst),
      .start  (start),
      .halted (halted),
      .busy   (busy),
      .mem    (mem_bus.core),
      .rf     (rf_bus.ctrl),
      .alu_op (alu_op),
      .imm    (imm),
      .wb_sel (wb_sel)
   );

   // Operands come straight from the registered read ports
   alu alu_inst (
      .a      (rf_bus.rd_data0),
      .b      (rf_bus.rd_data1),
      .op     (alu_op),
      .result (alu_result)
   );

   main_memory #(.MEM_DEPTH(MEM_DEPTH)) main_memory_inst (
      .clk       (clk),
      .rst       (rst),
      .mem       (mem_bus.mem),
      .busy      (busy),
      .load_req  (load_req),
      .load_addr (load_addr),
      .load_data (load_data),
      .load_ack  (load_ack)
   );

   register_file register_file_inst (
      .clk        (clk),
      .rst        (rst),
      .rf         (rf_bus.file),
      .busy       (busy),
      .wb_sel     (wb_sel),
      .imm        (imm),
      .alu_result (alu_result),
      .mem_rdata  (mem_bus.rdata),
      .dbg_req    (dbg_req),
      .dbg_reg    (dbg_reg),
      .dbg_data   (dbg_data),
      .dbg_ack    (dbg_ack)
   );

endmodule

`default_nettype wire

// ==== test/cpu_tb.sv ====
`default_nettype none

module cpu_tb;

   timeunit 1ns;
   timeprecision 100ps;

   // Load request held open during every run, completed after halt
   localparam logic [10:0] PEND_ADDR = 11'h7ff;
   localparam logic [31:0] PEND_WORD = 32'hc3a5_0f96;

   logic        clk;
   logic        rst;
   logic        start;
   wire         halted;
   logic        load_req;
   logic [10:0] load_addr;
   logic [31:0] load_data;
   wire         load_ack;
   logic        dbg_req;
   logic [4:0]  dbg_reg;
   wire  [31:0] dbg_data;
   wire         dbg_ack;

   logic [10:0] prog_addr [$];
   logic [31:0] prog_word [$];
   logic [4:0]  chk_reg [$];
   logic [31:0] chk_val [$];

   int unsigned words_loaded = 0;
   int          pass_count;
   int          fail_count;

   cpu_top cpu_top_inst (
      .clk       (clk),
      .rst       (rst),
      .start     (start),
      .halted    (halted),
      .load_req  (load_req),
      .load_addr (load_addr),
      .load_data (load_data),
      .load_ack  (load_ack),
      .dbg_req   (dbg_req),
      .dbg_reg   (dbg_reg),
      .dbg_data  (dbg_data),
      .dbg_ack   (dbg_ack)
   );

   initial clk = 1'b0;
   always #2 clk = ~clk;

   // Inputs change 1 ns after the rising edge
   task automatic step();
      @(posedge clk);
      #1;
   endtask

   task automatic load_word(input logic [10:0] addr, input logic [31:0] data);
      load_addr = addr;
      load_data = data;
      load_req  = 1'b1;
      step();
      while (!load_ack) step();
      load_req = 1'b0;
      step();
      while (load_ack) step();
      words_loaded++;
   endtask

   task automatic read_reg(input logic [4:0] idx, output logic [31:0] value);
      dbg_reg = idx;
      dbg_req = 1'b1;
      step();
      while (!dbg_ack) step();
      value   = dbg_data;
      dbg_req = 1'b0;
      step();
      while (dbg_ack) step();
   endtask

   task automatic run_test(input int num, input int exp_cycles);
      int          errors;
      int          cycles;
      logic [31:0] value;
      errors = 0;
      for (int i = 0; i < prog_addr.size(); i++) begin
         load_word(prog_addr[i], prog_word[i]);
      end
      start = 1'b1;
      step();
      start     = 1'b0;
      load_addr = PEND_ADDR;
      load_data = PEND_WORD;
      load_req  = 1'b1;
      // Edge that took start counts as the first cycle
      cycles = 1;
      while (!halted) begin
         step();
         cycles++;
         if (load_ack && !halted) begin
            $display("[ERROR] test %0d load_ack: got %0h expected %0h while running",
                     num, load_ack, 1'b0);
            errors++;
         end
      end
      if (cycles != exp_cycles) begin
         $display("[ERROR] test %0d cycle_count: got %0h expected %0h",
                  num, cycles, exp_cycles);
         errors++;
      end
      while (!load_ack) step();
      load_req = 1'b0;
      step();
      while (load_ack) step();
      for (int i = 0; i < chk_reg.size(); i++) begin
         read_reg(chk_reg[i], value);
         if (value !== chk_val[i]) begin
            $display("[ERROR] test %0d dbg_data r%0d: got %08h expected %08h",
                     num, chk_reg[i], value, chk_val[i]);
            errors++;
         end
      end
      if (errors == 0) begin
         pass_count++;
         $display("test %0d passed in %0d cycles", num, cycles);
      end else begin
         fail_count++;
         $display("test %0d failed with %0d errors", num, errors);
      end
   endtask

   initial begin : main
      int                fd;
      int                code;
      int                test_num;
      int                exp_cycles;
      logic [31:0]       f0;
      logic [31:0]       f1;
      logic [63:0]       tok;
      logic [8*120-1:0]  line;
      logic              done;
      rst        = 1'b0;
      start      = 1'b0;
      load_req   = 1'b0;
      load_addr  = '0;
      load_data  = '0;
      dbg_req    = 1'b0;
      dbg_reg    = '0;
      pass_count = 0;
      fail_count = 0;
      exp_cycles = 0;
      test_num   = 0;
      repeat (3) @(posedge clk);
      #1;
      rst = 1'b1;
      step();
      fd = $fopen("test/cpu_golden.txt", "r");
      if (fd == 0) begin
         $display("Could not open test/cpu_golden.txt for reading");
         fail_count++;
      end else begin
         done = 1'b0;
         while (!done) begin
            code = $fscanf(fd, " %s", tok);
            if (code != 1) begin
               done = 1'b1;
            end else if (tok == "#") begin
               code = $fgets(line, fd);
            end else if (tok == "P") begin
               code = $fscanf(fd, "%h %h", f0, f1);
               prog_addr.push_back(f0[10:0]);
               prog_word.push_back(f1);
            end else if (tok == "R") begin
               code = $fscanf(fd, "%h %h", f0, f1);
               chk_reg.push_back(f0[4:0]);
               chk_val.push_back(f1);
            end else if (tok == "C") begin
               code = $fscanf(fd, "%h", f0);
               exp_cycles = f0;
            end else if (tok == "E") begin
               test_num++;
               run_test(test_num, exp_cycles);
               prog_addr.delete();
               prog_word.delete();
               chk_reg.delete();
               chk_val.delete();
            end else begin
               $display("Unknown record %0s in the golden file", tok);
               fail_count++;
               done = 1'b1;
            end
         end
         $fclose(fd);
      end
      $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
      if (fail_count == 0 && pass_count > 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

   // Limit grows with every program word loaded
   initial begin : watchdog
      int unsigned cycles_seen;
      cycles_seen = 0;
      while (cycles_seen <= 2000 + 50 * words_loaded) begin
         @(posedge clk);
         cycles_seen++;
      end
      $display("Timeout: the run did not finish within %0d cycles", cycles_seen);
      $display("TEST FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// ==== test/cpu_golden.txt ====
# P addr word = program word, R reg value = expected register after halt
# C cycles = start to halted, E = run the test; all fields hex
# LDI sign extension, r0 stays zero
P 000 08401234
P 001 08808001
P 002 08005555
P 003 30000000
R 01 00001234
R 02 ffff8001
R 00 00000000
C 15
E
# ALU operations on r1 = -10 and r2 = 3
P 000 0840fff6
P 001 08800003
P 002 20c22000
P 003 21022001
P 004 21422002
P 005 21822003
P 006 21c22004
P 007 22022005
P 008 22422006
P 009 22822007
P 00a 30000000
R 03 fffffff9
R 04 fffffff3
R 05 00000002
R 06 fffffff7
R 07 fffffff5
R 08 ffffffb0
R 09 1ffffffe
R 0a 00000001
C 38
E
# Store r2 at address in r1, load back into r3
P 000 08400100
P 001 0880abcd
P 002 18022000
P 003 10c20000
P 004 30000000
R 03 ffffabcd
C 1a
E
# Loop sums 3+2+1, untaken JNZ then taken JNZ over an LDI of r1
P 000 08400003
P 001 08800000
P 002 08c00001
P 003 09000005
P 004 0940000b
P 005 20841000
P 006 20423001
P 007 28024000
P 008 28025000
P 009 28065000
P 00a 08400bad
P 00b 09c00077
P 00c 30000000
R 01 00000000
R 02 00000006
R 07 00000077
C 5b
E
# Held load from the previous run landed at 7ff
P 000 00000000
P 001 0a4007ff
P 002 12920000
P 003 30000000
R 0a c3a50f96
C 15
E

// ==== build.f ====
design/cpu_isa_pkg.sv
design/cpu_ctrl_pkg.sv
design/cpu_ifs.sv
design/fetch_sequencer.sv
design/alu.sv
design/main_memory.sv
design/register_file.sv
design/cpu_top.sv
test/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: cpu

sources:
  - design/cpu_isa_pkg.sv
  - design/cpu_ctrl_pkg.sv
  - design/cpu_ifs.sv
  - design/fetch_sequencer.sv
  - design/alu.sv
  - design/main_memory.sv
  - design/register_file.sv
  - design/cpu_top.sv
  - target: test
    files:
      - test/cpu_tb.sv
